/* hw/mul_pkg.sv */
/*
 * RV64 multiply unit shared definitions.
 * Holds the operand and product widths, the RV64M multiply
 * operation codes (funct3 order, MULW appended) and the state
 * encoding of the iterative shift-and-add engine.
 */
`default_nettype none

package mul_pkg;

    localparam int XLEN  = 64;
    localparam int DXLEN = 2 * XLEN;
    localparam int WLEN  = 32; // Word width used by MULW.

    typedef logic [XLEN-1:0]  xlen_t;
    typedef logic [DXLEN-1:0] dxlen_t;

    // Values 0 to 3 follow funct3 of the OP major opcode.
    typedef enum logic [2:0] {
        OP_MUL    = 3'd0,
        OP_MULH   = 3'd1,
        OP_MULHSU = 3'd2,
        OP_MULHU  = 3'd3,
        OP_MULW   = 3'd4
    } mul_op_t;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_RUN  = 2'd1,
        ST_DONE = 2'd2
    } core_state_t;

endpackage

`default_nettype wire

/* hw/mul_operand_prep.sv */
/*
 * Multiply operand preparation.
 * Decodes the operation, reduces signed operands to unsigned
 * magnitudes and computes the sign of the final product.
 * MULW operands are cut to their low word.
 */
`timescale 1ns/10ps
`default_nettype none

module mul_operand_prep (
    input  wire mul_pkg::mul_op_t op,
    input  wire mul_pkg::xlen_t   a,
    input  wire mul_pkg::xlen_t   b,
    output mul_pkg::xlen_t        mag_a,
    output mul_pkg::xlen_t        mag_b,
    output logic                  negate
);

    logic signed_a;
    logic signed_b;
    logic word_op;
    logic sign_a;
    logic sign_b;

    always_comb begin
        signed_a = 1'b0;
        signed_b = 1'b0;
        word_op  = 1'b0;
        case (op)
            mul_pkg::OP_MUL,
            mul_pkg::OP_MULH: begin
                signed_a = 1'b1;
                signed_b = 1'b1;
            end
            mul_pkg::OP_MULHSU: begin
                signed_a = 1'b1; // Multiplier stays unsigned.
            end
            mul_pkg::OP_MULW: begin
                word_op = 1'b1;
            end
            default: begin
                signed_a = 1'b0;
            end
        endcase
    end

    assign sign_a = signed_a && a[mul_pkg::XLEN-1];
    assign sign_b = signed_b && b[mul_pkg::XLEN-1];

    // The most negative value maps onto 2^63, which is still a valid magnitude.
    always_comb begin
        if (word_op) begin
            mag_a = {{(mul_pkg::XLEN-mul_pkg::WLEN){1'b0}}, a[mul_pkg::WLEN-1:0]};
            mag_b = {{(mul_pkg::XLEN-mul_pkg::WLEN){1'b0}}, b[mul_pkg::WLEN-1:0]};
        end else begin
            mag_a = sign_a ? (~a + 1'b1) : a;
            mag_b = sign_b ? (~b + 1'b1) : b;
        end
    end

    assign negate = sign_a ^ sign_b; // Low word of MULW needs no sign fix.

endmodule

`default_nettype wire

/* hw/mul_shift_add_core.sv */
/*
 * Iterative shift-and-add multiplier engine.
 * Multiplies two unsigned magnitudes one multiplier bit per cycle
 * into a double-width product. Iteration ends as soon as no set
 * multiplier bits remain, and done flags the final product.
 */
`timescale 1ns/10ps
`default_nettype none

module mul_shift_add_core (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   start,
    input  wire mul_pkg::xlen_t   mag_a,
    input  wire mul_pkg::xlen_t   mag_b,
    output mul_pkg::dxlen_t       product,
    output logic                  done
);

    mul_pkg::core_state_t state;
    mul_pkg::core_state_t state_next;
    mul_pkg::dxlen_t      multiplicand;
    mul_pkg::xlen_t       multiplier;
    mul_pkg::dxlen_t      acc;
    mul_pkg::dxlen_t      addend;

    assign addend = multiplier[0] ? multiplicand : '0;

    always_comb begin
        state_next = state;
        case (state)
            mul_pkg::ST_IDLE: begin
                if (start) begin
                    // A zero multiplier skips the run phase entirely.
                    state_next = (mag_b == '0) ? mul_pkg::ST_DONE : mul_pkg::ST_RUN;
                end
            end
            mul_pkg::ST_RUN: begin
                if (multiplier[mul_pkg::XLEN-1:1] == '0) begin // Highest set bit now.
                    state_next = mul_pkg::ST_DONE;
                end
            end
            default: begin
                state_next = mul_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= mul_pkg::ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            multiplicand <= {{mul_pkg::XLEN{1'b0}}, mag_a};
            multiplier   <= mag_b;
            acc          <= '0;
        end else if (state == mul_pkg::ST_RUN) begin
            acc          <= acc + addend;
            multiplicand <= multiplicand << 1;
            multiplier   <= multiplier >> 1;
        end
    end

    assign product = acc; // Holds until the next start.
    assign done    = (state == mul_pkg::ST_DONE);

    start_only_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        start |-> state == mul_pkg::ST_IDLE
    );

    done_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |=> !done
    );

endmodule

`default_nettype wire

/* hw/mul_result_format.sv */
/*
 * Multiply result formatting.
 * Restores the sign of the full double-width product and picks
 * the low half, the high half or the sign-extended low word
 * according to the operation.
 */
`timescale 1ns/10ps
`default_nettype none

module mul_result_format (
    input  wire mul_pkg::mul_op_t op,
    input  wire mul_pkg::dxlen_t  product,
    input  wire                   negate,
    output mul_pkg::xlen_t        result
);

    mul_pkg::dxlen_t signed_product;
    mul_pkg::xlen_t  low_half;
    mul_pkg::xlen_t  high_half;
    mul_pkg::xlen_t  word_ext;

    // Negating all 128 bits keeps the carry into the high half exact.
    assign signed_product = negate ? (~product + 1'b1) : product;

    assign low_half  = signed_product[mul_pkg::XLEN-1:0];
    assign high_half = signed_product[mul_pkg::DXLEN-1:mul_pkg::XLEN];
    assign word_ext  = {
        {(mul_pkg::XLEN-mul_pkg::WLEN){signed_product[mul_pkg::WLEN-1]}},
        signed_product[mul_pkg::WLEN-1:0]
    };

    always_comb begin
        case (op)
            mul_pkg::OP_MULH,
            mul_pkg::OP_MULHSU,
            mul_pkg::OP_MULHU: begin
                result = high_half;
            end
            mul_pkg::OP_MULW: begin
                result = word_ext;
            end
            default: begin
                result = low_half; // MUL and unused codes.
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/mul_unit.sv */
/*
 * RV64M multiply unit.
 * Accepts one request at a time over a valid/ready port, runs it
 * through operand preparation, the shift-and-add engine and result
 * formatting, and holds the result in a response register until
 * the consumer takes it.
 */
`timescale 1ns/10ps
`default_nettype none

module mul_unit (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   req_valid,
    output logic                  req_ready,
    input  wire mul_pkg::mul_op_t req_op,
    input  wire mul_pkg::xlen_t   req_a,
    input  wire mul_pkg::xlen_t   req_b,
    output logic                  resp_valid,
    input  wire                   resp_ready,
    output mul_pkg::xlen_t        resp_data
);

    logic             busy;
    logic             accept;
    logic             start;
    logic             done;
    logic             negate;
    mul_pkg::mul_op_t op_q;
    mul_pkg::xlen_t   a_q;
    mul_pkg::xlen_t   b_q;
    mul_pkg::xlen_t   mag_a;
    mul_pkg::xlen_t   mag_b;
    mul_pkg::xlen_t   result;
    mul_pkg::dxlen_t  product;

    // Only one operation may be in flight, including a pending response.
    assign req_ready = !busy && !resp_valid;
    assign accept    = req_valid && req_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            start      <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            start <= accept; // One-cycle pulse after acceptance.
            if (accept) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
            if (done) begin
                resp_valid <= 1'b1;
            end else if (resp_valid && resp_ready) begin
                resp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q <= req_op;
            a_q  <= req_a;
            b_q  <= req_b;
        end
        if (done) begin
            resp_data <= result;
        end
    end

    mul_operand_prep u_prep (
        .op     (op_q),
        .a      (a_q),
        .b      (b_q),
        .mag_a  (mag_a),
        .mag_b  (mag_b),
        .negate (negate)
    );

    mul_shift_add_core u_core (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .mag_a   (mag_a),
        .mag_b   (mag_b),
        .product (product),
        .done    (done)
    );

    mul_result_format u_format (
        .op      (op_q),
        .product (product),
        .negate  (negate),
        .result  (result)
    );

    resp_held_under_backpressure: assert property (
        @(posedge clk) disable iff (!rst_n)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_data)
    );

endmodule

`default_nettype wire

/* verification/mul_tb_clk.sv */
/*
 * Testbench clock and reset generator.
 * Makes a 40 ns clock and holds the active-low reset for the
 * first eight rising edges.
 */
`timescale 1ns/10ps
`default_nettype none

module mul_tb_clk (
    output logic clk,
    output logic rst_n
);

    localparam int PERIOD      = 40;
    localparam int RESET_EDGES = 8;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_EDGES) @(posedge clk);
        #1 rst_n = 1'b1; // Released just after an edge, like the other stimulus.
    end

endmodule

`default_nettype wire

/* verification/mul_tb.sv */
/*
 * Testbench for the RV64M multiply unit.
 * Drives requests through the valid/ready port, applies random
 * back-pressure on the response port and checks every result
 * against a reference model of the five multiply operations.
 */
`timescale 1ns/10ps
`default_nettype none

module mul_tb;

    localparam int REQ_TIMEOUT  = 500;
    localparam int RESP_TIMEOUT = 2000;

    logic             clk;
    logic             rst_n;
    logic             req_valid;
    logic             req_ready;
    mul_pkg::mul_op_t req_op;
    mul_pkg::xlen_t   req_a;
    mul_pkg::xlen_t   req_b;
    logic             resp_valid;
    logic             resp_ready;
    mul_pkg::xlen_t   resp_data;

    mul_pkg::xlen_t exp_q[$];
    integer         seed;
    logic           bp_enable;
    int             check_count;
    int             error_count;
    int             test_checks;
    int             test_errors;

    mul_tb_clk u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mul_unit u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_op     (req_op),
        .req_a      (req_a),
        .req_b      (req_b),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp_data  (resp_data)
    );

    // Exact 128-bit product of the extended operands, then the part the op asks for.
    function automatic mul_pkg::xlen_t ref_mul(
        input mul_pkg::mul_op_t op,
        input mul_pkg::xlen_t   a,
        input mul_pkg::xlen_t   b
    );
        mul_pkg::dxlen_t ext_a;
        mul_pkg::dxlen_t ext_b;
        mul_pkg::dxlen_t full;
        ext_a = {{mul_pkg::XLEN{1'b0}}, a};
        ext_b = {{mul_pkg::XLEN{1'b0}}, b};
        if (op == mul_pkg::OP_MUL || op == mul_pkg::OP_MULH || op == mul_pkg::OP_MULHSU) begin
            ext_a = {{mul_pkg::XLEN{a[mul_pkg::XLEN-1]}}, a};
        end
        if (op == mul_pkg::OP_MUL || op == mul_pkg::OP_MULH) begin
            ext_b = {{mul_pkg::XLEN{b[mul_pkg::XLEN-1]}}, b};
        end
        full = ext_a * ext_b; // Wraps modulo 2^128, so signed products come out exact.
        case (op)
            mul_pkg::OP_MULH,
            mul_pkg::OP_MULHSU,
            mul_pkg::OP_MULHU: ref_mul = full[127:64];
            mul_pkg::OP_MULW:  ref_mul = {{32{full[31]}}, full[31:0]};
            default:           ref_mul = full[63:0];
        endcase
    endfunction

    function automatic mul_pkg::mul_op_t pick_op(input int sel);
        case (sel)
            0:       pick_op = mul_pkg::OP_MUL;
            1:       pick_op = mul_pkg::OP_MULH;
            2:       pick_op = mul_pkg::OP_MULHSU;
            3:       pick_op = mul_pkg::OP_MULHU;
            default: pick_op = mul_pkg::OP_MULW;
        endcase
    endfunction

    function automatic mul_pkg::xlen_t rand_word();
        rand_word = {$random(seed), $random(seed)};
    endfunction

    task automatic abort_run(input string why);
        $display("ERROR at %0t: %s", $time, why);
        $display("TB FAILED");
        $finish;
    endtask

    // Called just after a rising edge and returns just after one.
    task automatic send_request(
        input mul_pkg::mul_op_t op,
        input mul_pkg::xlen_t   a,
        input mul_pkg::xlen_t   b
    );
        int   waited;
        logic accepted;
        waited    = 0;
        accepted  = 1'b0;
        req_valid = 1'b1;
        req_op    = op;
        req_a     = a;
        req_b     = b;
        while (!accepted && waited < REQ_TIMEOUT) begin
            @(negedge clk);
            if (req_ready) begin
                accepted = 1'b1; // Taken on the coming edge.
                exp_q.push_back(ref_mul(op, a, b));
            end else begin
                waited++;
            end
            @(posedge clk);
            #1;
        end
        req_valid = 1'b0;
        if (!accepted) begin
            abort_run("request was not accepted within the timeout");
        end
    endtask

    task automatic drain_responses();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < RESP_TIMEOUT) begin
            waited++;
            @(posedge clk);
            #1;
        end
        if (exp_q.size() != 0) begin
            abort_run("outstanding responses never arrived");
        end else begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic open_test();
        test_checks = check_count;
        test_errors = error_count;
    endtask

    task automatic close_test(input string name);
        drain_responses();
        $display("test %s: %0d checks, %0d errors", name,
                 check_count - test_checks, error_count - test_errors);
    endtask

    initial begin : response_checker
        int             waited;
        int             stall;
        mul_pkg::xlen_t held;
        mul_pkg::xlen_t expected;
        resp_ready = 1'b0;
        waited     = 0;
        while (rst_n !== 1'b1 && waited < RESP_TIMEOUT) begin
            waited++;
            @(posedge clk);
        end
        if (rst_n !== 1'b1) begin
            abort_run("reset was never released");
        end
        forever begin
            waited = 0;
            @(negedge clk);
            while (!resp_valid && waited < RESP_TIMEOUT) begin
                waited++;
                @(posedge clk);
                #1;
                resp_ready = !bp_enable;
                @(negedge clk);
            end
            if (!resp_valid) begin
                abort_run("no response from the DUT within the timeout");
            end else begin
                held = resp_data;
                if (!resp_ready) begin
                    stall = {$random(seed)} % 6;
                    for (int i = 0; i < stall; i++) begin
                        @(posedge clk);
                        @(negedge clk);
                        check_count += 2;
                        assert (resp_valid && resp_data === held) else begin
                            $display("MISMATCH at %0t: held response changed, %h -> %h",
                                     $time, held, resp_data);
                            error_count++;
                        end
                        assert (!req_ready) else begin
                            $display("ERROR at %0t: request port ready during back-pressure",
                                     $time);
                            error_count++;
                        end
                    end
                    @(posedge clk);
                    #1;
                    resp_ready = 1'b1;
                    @(negedge clk);
                end
                check_count++;
                assert (!req_ready) else begin
                    $display("ERROR at %0t: request port ready with a response pending",
                             $time);
                    error_count++;
                end
                if (exp_q.size() == 0) begin
                    abort_run("response arrived with no request outstanding");
                end else begin
                    expected = exp_q.pop_front();
                    check_count++;
                    assert (resp_data === expected) else begin
                        $display("MISMATCH at %0t: resp_data %h, expected %h",
                                 $time, resp_data, expected);
                        error_count++;
                    end
                end
                @(posedge clk); // The response is taken on this edge.
                #1;
                resp_ready = !bp_enable;
            end
        end
    end

    initial begin : stimulus
        mul_pkg::xlen_t   corners[5];
        mul_pkg::xlen_t   small_b[6];
        mul_pkg::mul_op_t op;
        int               waited;
        seed        = 32'h2859fed5;
        req_valid   = 1'b0;
        req_op      = mul_pkg::OP_MUL;
        req_a       = '0;
        req_b       = '0;
        bp_enable   = 1'b0;
        check_count = 0;
        error_count = 0;
        test_checks = 0;
        test_errors = 0;
        corners[0]  = 64'h0000_0000_0000_0000;
        corners[1]  = 64'h0000_0000_0000_0001;
        corners[2]  = 64'hffff_ffff_ffff_ffff;
        corners[3]  = 64'h8000_0000_0000_0000;
        corners[4]  = 64'h7fff_ffff_ffff_ffff;
        small_b[0]  = 64'd0;
        small_b[1]  = 64'd1;
        small_b[2]  = 64'd2;
        small_b[3]  = 64'd3;
        small_b[4]  = 64'd5;
        small_b[5]  = 64'd7;
        waited      = 0;
        while (rst_n !== 1'b1 && waited < RESP_TIMEOUT) begin
            waited++;
            @(posedge clk);
            #2;
        end
        if (rst_n !== 1'b1) begin
            abort_run("reset was never released");
        end
        @(posedge clk);
        #1;

        open_test();
        check_count += 2;
        assert (!resp_valid) else begin
            $display("ERROR at %0t: resp_valid high right after reset", $time);
            error_count++;
        end
        assert (req_ready) else begin
            $display("ERROR at %0t: req_ready low right after reset", $time);
            error_count++;
        end
        close_test("reset state");

        open_test();
        for (int i = 0; i < 40; i++) begin
            send_request(mul_pkg::OP_MUL, rand_word(), rand_word());
        end
        close_test("MUL random");

        open_test();
        for (int k = 1; k <= 3; k++) begin
            op = pick_op(k);
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    send_request(op, corners[i], corners[j]);
                end
            end
            for (int i = 0; i < 20; i++) begin
                send_request(op, rand_word(), rand_word());
            end
        end
        close_test("high half ops");

        open_test();
        send_request(mul_pkg::OP_MULW, 64'hdead_beef_0001_0000, 64'h1234_5678_0000_8000);
        send_request(mul_pkg::OP_MULW, 64'hffff_ffff_ffff_ffff, 64'h0000_0001_0000_0003);
        send_request(mul_pkg::OP_MULW, 64'h0000_0000_7fff_ffff, 64'h0000_0000_0000_0002);
        for (int i = 0; i < 30; i++) begin
            send_request(mul_pkg::OP_MULW, rand_word(), rand_word());
        end
        close_test("MULW");

        open_test();
        bp_enable = 1'b1; // The checker now stalls every response.
        for (int i = 0; i < 30; i++) begin
            send_request(pick_op({$random(seed)} % 5), rand_word(), rand_word());
        end
        close_test("back-pressure");
        bp_enable = 1'b0;

        open_test();
        for (int k = 0; k < 5; k++) begin
            for (int i = 0; i < 6; i++) begin
                send_request(pick_op(k), rand_word(), small_b[i]);
            end
        end
        for (int i = 0; i < 200; i++) begin
            send_request(pick_op({$random(seed)} % 5), rand_word(), rand_word());
        end
        close_test("small and back-to-back");

        $display("total: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
hw/mul_pkg.sv
hw/mul_operand_prep.sv
hw/mul_shift_add_core.sv
hw/mul_result_format.sv
hw/mul_unit.sv
verification/mul_tb_clk.sv
verification/mul_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the multiply unit testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -Wno-fatal \
    --top-module mul_tb \
    -f sim.f

# The verdict comes from the printed result line, not the exit status.
out=$(./obj_dir/Vmul_tb 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TB PASSED"; then
    exit 0
else
    echo "Simulation did not report a pass." >&2
    exit 1
fi
